// ==== hdl/ifu_consts.svh ====
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Instruction format
//////////////////////////////////////////////////////////////////////

// Full instruction word
`define IFU_WORD_W		32

// Logical and physical port ids share one width
`define IFU_ID_W		4

// Port table depth, one entry per logical id
`define IFU_NUM_IDS		16

//////////////////////////////////////////////////////////////////////
// Status counters
//////////////////////////////////////////////////////////////////////

// Committed routes, wraps at 256
`define IFU_DONE_CNT_W	8

// Rejected self-routes, wraps at 16
`define IFU_REJ_CNT_W	4

// Rejected count on top, committed count below
`define IFU_STATUS_W	(`IFU_REJ_CNT_W + `IFU_DONE_CNT_W)

`endif

// ==== hdl/ifu_pkg.sv ====
`include "ifu_consts.svh"

package ifu_pkg;

	// Instruction kind, bit 31 of every word
	typedef enum logic {
		MOVE	= 1'b0,
		CONFIG	= 1'b1
	} instr_kind_e;

	// Move view
	typedef struct packed {
		instr_kind_e						kind;
		logic								release_bit;
		logic [`IFU_WORD_W-2-2*`IFU_ID_W-1:0]	reserved;
		logic [`IFU_ID_W-1:0]				dst_id;
		logic [`IFU_ID_W-1:0]				src_id;
	} move_fields_t;

	// Configuration view, one port table entry
	typedef struct packed {
		instr_kind_e						kind;
		logic [`IFU_WORD_W-1-2*`IFU_ID_W-1:0]	reserved;
		logic [`IFU_ID_W-1:0]				logical_id;
		logic [`IFU_ID_W-1:0]				physical_id;
	} config_fields_t;

	// Same 32 bits, decoded by kind
	typedef union packed {
		move_fields_t						move;
		config_fields_t						cfg;
	} instr_word_t;

endpackage

// ==== hdl/ifu_fetch.sv ====
`timescale 1ns/1ps

module ifu_fetch (
	input  logic					clock,
	input  logic					reset,

	// Four-phase input port
	input  logic					in_req,
	input  ifu_pkg::instr_word_t	in_word,
	output logic					in_ack,

	// First pipeline slot
	output ifu_pkg::instr_word_t	word,
	output logic					valid,
	input  logic					stall
);

	logic load_en;
	logic capture;

	// Slot is free, or drains this cycle
	assign load_en = ~valid | ~stall;

	// New request only while ack is low, so each request is taken once
	assign capture = in_req & ~in_ack & load_en;

	//////////////////////////////////////////////////////////////////////
	// Ack phase and slot occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			in_ack <= 1'b0;
			valid <= 1'b0;
		end else begin
			// Ack follows the capture, drops once req is released
			if (capture) begin
				in_ack <= 1'b1;
			end else if (~in_req) begin
				in_ack <= 1'b0;
			end

			if (capture) begin
				valid <= 1'b1;
			end else if (load_en) begin
				valid <= 1'b0;
			end
		end
	end

	// Captured word
	always_ff @(posedge clock) begin
		if (capture) begin
			word <= in_word;
		end
	end

endmodule

// ==== hdl/ifu_rename.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_rename (
	input  logic					clock,
	input  logic					reset,

	// From fetch slot
	input  ifu_pkg::instr_word_t	word,
	input  logic					word_valid,
	output logic					word_stall,

	// Renamed route slot
	output logic [`IFU_ID_W-1:0]	dst_port,
	output logic [`IFU_ID_W-1:0]	src_port,
	output logic					release_bit,
	output logic					valid,
	input  logic					stall
);

	import ifu_pkg::*;

	// Logical to physical map
	logic [`IFU_ID_W-1:0]	port_table [`IFU_NUM_IDS];

	logic					load_en;
	logic					take;
	logic					is_move;
	logic					is_cfg;

	//////////////////////////////////////////////////////////////////////
	// Decode and handshake
	//////////////////////////////////////////////////////////////////////

	assign is_move = (word.move.kind == MOVE);
	assign is_cfg = (word.cfg.kind == CONFIG);

	assign load_en = ~valid | ~stall;
	assign take = word_valid & load_en;

	// Fetch word waits while our slot is held
	assign word_stall = word_valid & ~load_en;

	//////////////////////////////////////////////////////////////////////
	// Port table and slot valid
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
			// Identity map out of reset
			for (int i = 0; i < `IFU_NUM_IDS; i++) begin
				port_table[i] <= i[`IFU_ID_W-1:0];
			end
		end else begin
			// Config words end here and leave no route behind
			if (load_en) begin
				valid <= word_valid & is_move;
			end

			// Written as the word leaves fetch, so the next move sees it
			if (take & is_cfg) begin
				port_table[word.cfg.logical_id] <= word.cfg.physical_id;
			end
		end
	end

	// Move lookup
	always_ff @(posedge clock) begin
		if (take & is_move) begin
			dst_port <= port_table[word.move.dst_id];
			src_port <= port_table[word.move.src_id];
			release_bit <= word.move.release_bit;
		end
	end

endmodule

// ==== hdl/ifu_port_check.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_port_check (
	input  logic						clock,
	input  logic						reset,

	// From rename slot
	input  logic [`IFU_ID_W-1:0]		dst_port,
	input  logic [`IFU_ID_W-1:0]		src_port,
	input  logic						release_bit,
	input  logic						route_valid,
	output logic						route_stall,

	// Checked route slot
	output logic [`IFU_ID_W-1:0]		chk_dst_port,
	output logic [`IFU_ID_W-1:0]		chk_src_port,
	output logic						chk_release,
	output logic						valid,
	input  logic						stall,

	output logic [`IFU_REJ_CNT_W-1:0]	rejected
);

	logic self_route;
	logic load_en;
	logic take;

	// Both ends on one physical port
	assign self_route = (dst_port == src_port);

	assign load_en = ~valid | ~stall;
	assign take = route_valid & ~self_route & load_en;

	// Self-routes are dropped at once and never wait
	assign route_stall = route_valid & ~self_route & ~load_en;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
			rejected <= '0;
		end else begin
			if (load_en) begin
				valid <= route_valid & ~self_route;
			end

			if (route_valid & self_route) begin
				rejected <= rejected + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			chk_dst_port <= dst_port;
			chk_src_port <= src_port;
			chk_release <= release_bit;
		end
	end

endmodule

// ==== hdl/ifu_commit.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_commit (
	input  logic						clock,
	input  logic						reset,

	// From port check slot
	input  logic [`IFU_ID_W-1:0]		dst_port,
	input  logic [`IFU_ID_W-1:0]		src_port,
	input  logic						release_bit,
	input  logic						route_valid,
	output logic						route_stall,

	// Four-phase output port
	output logic						out_req,
	output logic [`IFU_ID_W-1:0]		out_dst_port,
	output logic [`IFU_ID_W-1:0]		out_src_port,
	output logic						out_release,
	input  logic						out_ack,

	output logic [`IFU_DONE_CNT_W-1:0]	committed
);

	localparam logic [1:0] ST_IDLE		= 2'd0;
	localparam logic [1:0] ST_REQ		= 2'd1;
	localparam logic [1:0] ST_ACK_LOW	= 2'd2;

	logic [1:0]	state;
	logic		can_load;
	logic		load;

	// A new route only after the previous ack has fallen
	assign can_load = (state == ST_IDLE) | ((state == ST_ACK_LOW) & ~out_ack);
	assign load = route_valid & can_load;
	assign route_stall = route_valid & ~can_load;

	//////////////////////////////////////////////////////////////////////
	// Output handshake FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			out_req <= 1'b0;
			committed <= '0;
		end else if (load) begin
			state <= ST_REQ;
		end else begin
			case (state)
				ST_REQ: begin
					// Req rises one edge after load, falls one edge after ack
					if (~out_req) begin
						out_req <= 1'b1;
					end else if (out_ack) begin
						out_req <= 1'b0;
						committed <= committed + 1'b1;
						state <= ST_ACK_LOW;
					end
				end
				ST_ACK_LOW: begin
					if (~out_ack) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Fields stay stable for the whole exchange
	always_ff @(posedge clock) begin
		if (load) begin
			out_dst_port <= dst_port;
			out_src_port <= src_port;
			out_release <= release_bit;
		end
	end

endmodule

// ==== hdl/ifu_top.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_top (
	input  logic						clock,
	input  logic						reset,

	// Instruction input port
	input  logic						in_req,
	input  ifu_pkg::instr_word_t		in_word,
	output logic						in_ack,

	// Route output port
	output logic						out_req,
	output logic [`IFU_ID_W-1:0]		out_dst_port,
	output logic [`IFU_ID_W-1:0]		out_src_port,
	output logic						out_release,
	input  logic						out_ack,

	output logic [`IFU_STATUS_W-1:0]	status
);

	import ifu_pkg::*;

	// Fetch to rename
	instr_word_t				fetch_word;
	logic						fetch_valid;
	logic						fetch_stall;

	// Rename to port check
	logic [`IFU_ID_W-1:0]		rn_dst_port;
	logic [`IFU_ID_W-1:0]		rn_src_port;
	logic						rn_release;
	logic						rn_valid;
	logic						rn_stall;

	// Port check to commit
	logic [`IFU_ID_W-1:0]		pc_dst_port;
	logic [`IFU_ID_W-1:0]		pc_src_port;
	logic						pc_release;
	logic						pc_valid;
	logic						pc_stall;

	logic [`IFU_REJ_CNT_W-1:0]	rejected;
	logic [`IFU_DONE_CNT_W-1:0]	committed;

	//////////////////////////////////////////////////////////////////////
	// Pipeline stages
	//////////////////////////////////////////////////////////////////////

	ifu_fetch u_fetch (
		.clock			(clock),
		.reset			(reset),
		.in_req			(in_req),
		.in_word		(in_word),
		.in_ack			(in_ack),
		.word			(fetch_word),
		.valid			(fetch_valid),
		.stall			(fetch_stall)
	);

	ifu_rename u_rename (
		.clock			(clock),
		.reset			(reset),
		.word			(fetch_word),
		.word_valid		(fetch_valid),
		.word_stall		(fetch_stall),
		.dst_port		(rn_dst_port),
		.src_port		(rn_src_port),
		.release_bit	(rn_release),
		.valid			(rn_valid),
		.stall			(rn_stall)
	);

	ifu_port_check u_port_check (
		.clock			(clock),
		.reset			(reset),
		.dst_port		(rn_dst_port),
		.src_port		(rn_src_port),
		.release_bit	(rn_release),
		.route_valid	(rn_valid),
		.route_stall	(rn_stall),
		.chk_dst_port	(pc_dst_port),
		.chk_src_port	(pc_src_port),
		.chk_release	(pc_release),
		.valid			(pc_valid),
		.stall			(pc_stall),
		.rejected		(rejected)
	);

	ifu_commit u_commit (
		.clock			(clock),
		.reset			(reset),
		.dst_port		(pc_dst_port),
		.src_port		(pc_src_port),
		.release_bit	(pc_release),
		.route_valid	(pc_valid),
		.route_stall	(pc_stall),
		.out_req		(out_req),
		.out_dst_port	(out_dst_port),
		.out_src_port	(out_src_port),
		.out_release	(out_release),
		.out_ack		(out_ack),
		.committed		(committed)
	);

	// Status word, one cycle behind the counters
	always_ff @(posedge clock) begin
		if (reset) begin
			status <= '0;
		end else begin
			status <= {rejected, committed};
		end
	end

endmodule

// ==== verification/ifu_tb_table.svh ====
`ifndef IFU_TB_TABLE_SVH
`define IFU_TB_TABLE_SVH

// Columns: test, word, route expected, dst, src, release, ack delay in cycles
// An ack delay of ff takes a random delay from the LCG instead

typedef struct packed {
	logic [3:0]		test;
	instr_word_t	word;
	logic			route;
	logic [3:0]		dst;
	logic [3:0]		src;
	logic			rel;
	logic [7:0]		delay;
} row_t;

localparam int num_rows = 31;

localparam row_t stim_rows [num_rows] = '{
	// Identity map out of reset
	{4'd1, 32'h0000_0021, 1'b1, 4'h2, 4'h1, 1'b0, 8'd0},
	{4'd1, 32'h0000_00f0, 1'b1, 4'hf, 4'h0, 1'b0, 8'd0},
	{4'd1, 32'h0000_0079, 1'b1, 4'h7, 4'h9, 1'b0, 8'd2},
	// Config entries take effect on the next move
	{4'd2, 32'h8000_003a, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	{4'd2, 32'h0000_0035, 1'b1, 4'ha, 4'h5, 1'b0, 8'd1},
	{4'd2, 32'h8000_0051, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	{4'd2, 32'h0000_0035, 1'b1, 4'ha, 4'h1, 1'b0, 8'd0},
	{4'd2, 32'h8000_008c, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	{4'd2, 32'h0000_0032, 1'b1, 4'ha, 4'h2, 1'b0, 8'd3},
	{4'd2, 32'h0000_0085, 1'b1, 4'hc, 4'h1, 1'b0, 8'd0},
	// Release flag passes through
	{4'd3, 32'h4000_0046, 1'b1, 4'h4, 4'h6, 1'b1, 8'd0},
	{4'd3, 32'h4000_0053, 1'b1, 4'h1, 4'ha, 1'b1, 8'd1},
	{4'd3, 32'h0000_0046, 1'b1, 4'h4, 4'h6, 1'b0, 8'd0},
	// Self-routes, L5 and L1 both on port 1, then L0 moved onto port a
	{4'd4, 32'h0000_0066, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	{4'd4, 32'h0000_0051, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	{4'd4, 32'h0000_0030, 1'b1, 4'ha, 4'h0, 1'b0, 8'd0},
	{4'd4, 32'h8000_000a, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	{4'd4, 32'h4000_0030, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	{4'd4, 32'h0000_0003, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	// Slow consumer fills the pipe
	{4'd5, 32'h0000_0012, 1'b1, 4'h1, 4'h2, 1'b0, 8'd20},
	{4'd5, 32'h0000_0024, 1'b1, 4'h2, 4'h4, 1'b0, 8'hff},
	{4'd5, 32'h4000_0047, 1'b1, 4'h4, 4'h7, 1'b1, 8'hff},
	{4'd5, 32'h0000_0069, 1'b1, 4'h6, 4'h9, 1'b0, 8'hff},
	{4'd5, 32'h0000_00bc, 1'b1, 4'hb, 4'hc, 1'b0, 8'd30},
	{4'd5, 32'h0000_00de, 1'b1, 4'hd, 4'he, 1'b0, 8'hff},
	{4'd5, 32'h8000_0092, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	{4'd5, 32'h0000_0019, 1'b1, 4'h1, 4'h2, 1'b0, 8'hff},
	{4'd5, 32'h0000_00ef, 1'b1, 4'he, 4'hf, 1'b0, 8'd15},
	// Tail traffic before the final count
	{4'd6, 32'h0000_0092, 1'b0, 4'h0, 4'h0, 1'b0, 8'd0},
	{4'd6, 32'h0000_0078, 1'b1, 4'h7, 4'hc, 1'b0, 8'd0},
	{4'd6, 32'h4000_00f1, 1'b1, 4'hf, 4'h1, 1'b1, 8'd1}
};

`endif

// ==== verification/ifu_tb.sv ====
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_tb;

	import ifu_pkg::*;

	logic						clock;
	logic						reset;
	logic						in_req;
	instr_word_t				in_word;
	logic						in_ack;
	logic						out_req;
	logic [`IFU_ID_W-1:0]		out_dst_port;
	logic [`IFU_ID_W-1:0]		out_src_port;
	logic						out_release;
	logic						out_ack;
	logic [`IFU_STATUS_W-1:0]	status;

	`include "ifu_tb_table.svh"

	// Expected routes as {dst, src, release}, with their ack delays
	logic [2*`IFU_ID_W:0]	exp_routes [num_rows];
	int						ack_delays [num_rows];
	int						n_routes;
	logic [31:0]			lcg_state;
	int						errors;
	int						err_mark;
	int						tests_run;
	int						tests_failed;

	// Written only by the output monitor
	int						mon_errors;
	int						completed;
	int						out_idx;
	int						cap_row;
	int						cap_routes;
	logic					in_ack_q;
	logic					out_req_q;

	ifu_top UUT (
		.clock			(clock),
		.reset			(reset),
		.in_req			(in_req),
		.in_word		(in_word),
		.in_ack			(in_ack),
		.out_req		(out_req),
		.out_dst_port	(out_dst_port),
		.out_src_port	(out_src_port),
		.out_release	(out_release),
		.out_ack		(out_ack),
		.status			(status)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus and expected routes
	//////////////////////////////////////////////////////////////////////

	task automatic build_expected();
		n_routes = 0;
		for (int i = 0; i < num_rows; i++) begin
			if (stim_rows[i].route) begin
				exp_routes[n_routes] = {stim_rows[i].dst, stim_rows[i].src, stim_rows[i].rel};
				if (stim_rows[i].delay == 8'hff) begin
					ack_delays[n_routes] = (next_random() >> 16) % 24;
				end else begin
					ack_delays[n_routes] = int'(stim_rows[i].delay);
				end
				n_routes++;
			end
		end
	endtask

	// Producer side of the input port
	task automatic send_word(input instr_word_t w);
		@(posedge clock);
		#1;
		in_word = w;
		in_req = 1'b1;
		do @(negedge clock); while (in_ack !== 1'b1);
		@(posedge clock);
		#1 in_req = 1'b0;
		do @(negedge clock); while (in_ack !== 1'b0);
	endtask

	task automatic finish_test(input int test, input int last);
		int routes;
		int rejects;
		int errs;
		routes = 0;
		rejects = 0;
		for (int i = 0; i <= last; i++) begin
			if (stim_rows[i].route) begin
				routes++;
			end else if (stim_rows[i].word.move.kind == MOVE) begin
				rejects++;
			end
		end
		while (completed != routes || out_ack) @(posedge clock);
		// Rename, port check and the status register, one cycle each
		repeat (4) @(posedge clock);
		#1;
		assert (status[`IFU_STATUS_W-1:`IFU_DONE_CNT_W] == rejects[`IFU_REJ_CNT_W-1:0]) else begin
			errors++;
			$display("ERR %0t: rejected count %0d, expected %0d", $time,
				status[`IFU_STATUS_W-1:`IFU_DONE_CNT_W], rejects[`IFU_REJ_CNT_W-1:0]);
		end
		assert (status[`IFU_DONE_CNT_W-1:0] == routes[`IFU_DONE_CNT_W-1:0]) else begin
			errors++;
			$display("ERR %0t: committed count %0d, expected %0d", $time,
				status[`IFU_DONE_CNT_W-1:0], routes[`IFU_DONE_CNT_W-1:0]);
		end
		errs = errors + mon_errors - err_mark;
		err_mark = errors + mon_errors;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("Test %0d finished with %0d error(s)", test, errs);
	endtask

	initial begin
		reset = 1'b1;
		in_req = 1'b0;
		in_word = '0;
		lcg_state = 32'he77a_ab53;
		errors = 0;
		err_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		build_expected();
		repeat (8) @(posedge clock);
		#1 reset = 1'b0;
		for (int i = 0; i < num_rows; i++) begin
			send_word(stim_rows[i].word);
			if (i == num_rows - 1 || stim_rows[i + 1].test != stim_rows[i].test) begin
				finish_test(int'(stim_rows[i].test), i);
			end
		end
		assert (out_idx == n_routes && cap_row == num_rows) else begin
			errors++;
			$display("Traffic incomplete, %0d of %0d routes seen and %0d of %0d words taken",
				out_idx, n_routes, cap_row, num_rows);
		end
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			errors + mon_errors);
		if (errors + mon_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Consumer and output monitor
	//////////////////////////////////////////////////////////////////////

	initial begin
		int idx;
		int delay;
		idx = 0;
		out_ack = 1'b0;
		forever begin
			do @(negedge clock); while (out_req !== 1'b1);
			delay = (idx < n_routes) ? ack_delays[idx] : 0;
			idx++;
			repeat (delay) @(negedge clock);
			@(posedge clock);
			#1 out_ack = 1'b1;
			do @(negedge clock); while (out_req === 1'b1);
			@(posedge clock);
			#1 out_ack = 1'b0;
		end
	end

	always @(negedge clock) begin
		if (reset) begin
			mon_errors = 0;
			completed = 0;
			out_idx = 0;
			cap_row = 0;
			cap_routes = 0;
			in_ack_q = 1'b0;
			out_req_q = 1'b0;
		end else begin
			// Fetch, rename, port check and commit hold one route each
			if (in_ack && !in_ack_q) begin
				if (cap_row < num_rows && stim_rows[cap_row].route) begin
					cap_routes++;
				end
				cap_row++;
				assert (cap_routes - completed <= 4) else begin
					mon_errors++;
					$display("Word accepted at %0t while the pipeline was already full", $time);
				end
			end
			if (out_req && !out_req_q) begin
				assert (out_idx < n_routes) else begin
					mon_errors++;
					$display("Route issued at %0t when no more routes were expected", $time);
				end
				if (out_idx < n_routes) begin
					assert ({out_dst_port, out_src_port, out_release} == exp_routes[out_idx])
					else begin
						mon_errors++;
						$display("ERR %0t: route %0d is dst %h src %h rel %b, expected %h", $time,
							out_idx, out_dst_port, out_src_port, out_release, exp_routes[out_idx]);
					end
				end
				out_idx++;
			end
			if (!out_req && out_req_q) begin
				completed++;
			end
			in_ack_q = in_ack;
			out_req_q = out_req;
		end
	end

	// Watchdog
	initial begin
		repeat (num_rows * 40 + 100) @(posedge clock);
		$display("Timeout, traffic did not finish within %0d cycles", num_rows * 40 + 100);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+hdl
+incdir+verification
hdl/ifu_pkg.sv
hdl/ifu_fetch.sv
hdl/ifu_rename.sv
hdl/ifu_port_check.sv
hdl/ifu_commit.sv
hdl/ifu_top.sv
verification/ifu_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction path testbench

VERILATOR ?= verilator
TOP ?= ifu_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_MSG ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Output is kept in a shell variable and searched for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
